// ==== source/mbu_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types and widths for the Memory Bank Unit
// Holds the control unit address codes, the I/O cycle bundle and the
// register write request that the decoder hands to every bank
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package mbu_pkg;

   // Width of one bank register, which also sets the width of AEXT
   localparam int MBU_REG_W = 8;

   // Registers held in each bank
   localparam int BANK_DEPTH = 4;

   // Two banks give the eight registers MB0 to MB7
   localparam int NUM_BANKS = 2;

   // Address width of an entry inside one bank
   localparam int BANK_AW = $clog2(BANK_DEPTH);

   // Address width over all registers, bank select on top of the entry
   localparam int MBU_AW = $clog2(NUM_BANKS * BANK_DEPTH);

   ////////////////////////////////////////////////////////////////////////////
   // Control unit address codes
   ////////////////////////////////////////////////////////////////////////////

   // Read address codes the MBU answers to
   // Every other code belongs to some other unit and is ignored here
   typedef enum logic [4:0] {
      RADDR_READ_MBP = 5'b01101
   } mbu_raddr_e;

   // Write address codes the MBU answers to
   // The four AR writes index memory through MBP, MBD, MBS or IR
   typedef enum logic [4:0] {
      WADDR_WRITE_AR_MBP    = 5'b00100,
      WADDR_WRITE_AR_MBD    = 5'b00101,
      WADDR_WRITE_AR_MBS    = 5'b00110,
      WADDR_WRITE_AR_IDX    = 5'b00111,
      WADDR_WRITE_MBP       = 5'b01100,
      WADDR_WRITE_MBP_FLAGS = 5'b01101
   } mbu_waddr_e;

   ////////////////////////////////////////////////////////////////////////////
   // Bundles
   ////////////////////////////////////////////////////////////////////////////

   // One processor I/O cycle as seen by the MBU, all strobes active high
   typedef struct packed {
      logic [7:0] ab;
      logic       sysdev;
      logic       rd;
      logic       wr;
   } io_cycle_t;

   // Register write request, the same word goes to all banks
   // Only the bank whose enable bit is set takes it
   typedef struct packed {
      logic [BANK_AW-1:0]   wa;
      logic [NUM_BANKS-1:0] bank_we;
      logic [MBU_REG_W-1:0] wd;
   } mbu_wr_t;

endpackage

`default_nettype wire

// ==== source/mbu_write_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// Write side of the Memory Bank Unit
// Decodes the MBR window in I/O space and the control unit write-MBP
// codes, then steers one register write to the right bank
// Also keeps the enable flop that the first OUT to the MBR sets
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mbu_write_decode #(
   parameter logic [7:0] MBR_IO_BASE = 8'h08
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  mbu_pkg::io_cycle_t      io,
   input  mbu_pkg::mbu_waddr_e     waddr,
   input  logic [7:0]              ibus_in,
   output mbu_pkg::mbu_wr_t        wr_req,
   output logic                    enabled
);

   import mbu_pkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // Address decoding
   ////////////////////////////////////////////////////////////////////////////

   // High while the I/O cycle addresses one of the eight MBR ports
   logic io_mbr_sel;

   // An OUT to the MBR window
   logic io_wr;

   // The control unit writes MBP, with or without the flags
   logic cu_wr;

   // Register address chosen for this cycle's write
   logic [MBU_AW-1:0] wr_addr;

   // Bank that the chosen address falls in
   logic [MBU_AW-BANK_AW-1:0] wr_bank;

   // The window is eight ports wide, so only the top five address bits
   // take part in the match
   assign io_mbr_sel = io.sysdev && (io.ab[7:3] == MBR_IO_BASE[7:3]);
   assign io_wr      = io_mbr_sel && io.wr;

   // Both write-MBP codes land on register 0
   assign cu_wr = (waddr == WADDR_WRITE_MBP) || (waddr == WADDR_WRITE_MBP_FLAGS);

   // The I/O address has precedence over the fixed MBP address
   // A clash between the two can only be a software error, and the
   // original steering lets the I/O address through
   always_comb begin
      if (io_wr) begin
         wr_addr = io.ab[MBU_AW-1:0];
      end else begin
         wr_addr = '0;
      end
   end

   // Top bit of the address picks the bank, the rest picks the entry
   assign wr_bank = wr_addr[MBU_AW-1:BANK_AW];

   ////////////////////////////////////////////////////////////////////////////
   // Write request to the banks
   ////////////////////////////////////////////////////////////////////////////

   // One enable bit per bank, at most one of them set
   always_comb begin
      wr_req.bank_we = '0;
      if (io_wr || cu_wr) begin
         wr_req.bank_we[wr_bank] = 1'b1;
      end
   end

   // Entry and data are shared by every bank
   assign wr_req.wa = wr_addr[BANK_AW-1:0];

   // Writes always come from the internal bus
   assign wr_req.wd = ibus_in;

   ////////////////////////////////////////////////////////////////////////////
   // MBU enable
   ////////////////////////////////////////////////////////////////////////////

   // Out of reset the MBU keeps its registers off AEXT and the default
   // from the front panel shows instead
   // The first OUT to any MBR port brings it online and it then stays
   // on until the next reset
   // A write-MBP from the control unit alone leaves it disabled
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         enabled <= 1'b0;
      end else if (io_wr) begin
         enabled <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== source/mbu_bank.sv ====
////////////////////////////////////////////////////////////////////////////
// One bank of four MBU registers
// Takes the shared write request when its own enable is high and shows
// every entry to the read side at all times
// The top level builds the full register file from several of these
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mbu_bank (
   input  logic                     clk,
   input  logic                     rst_n,
   input  mbu_pkg::mbu_wr_t         wr_req,
   input  logic                     we,
   output logic [mbu_pkg::BANK_DEPTH-1:0][mbu_pkg::MBU_REG_W-1:0] q
);

   ////////////////////////////////////////////////////////////////////////////
   // Register storage
   ////////////////////////////////////////////////////////////////////////////

   // The registers come up as zero, so MBP points at bank 0 after reset
   // and any stray read before the first write is well defined

   // One entry changes per write, picked by the in-bank address
   // The read side taps the whole array, so there is no read port here
   // and a write shows on q from the next cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q <= '0;
      end else if (we) begin
         q[wr_req.wa] <= wr_req.wd;
      end
   end

   // The bank never sees which other bank is being written
   // Its own enable bit arrives on we, split out at the top level from
   // the request's per-bank enables

   // Writes take the full register width in one go
   // The old board split each register over two 4-bit register file
   // chips, which behaved as one 8-bit entry

   // Entries hold their value through reads and through writes to
   // other entries or other banks

endmodule

`default_nettype wire

// ==== source/mbu_read_select.sv ====
////////////////////////////////////////////////////////////////////////////
// Read side of the Memory Bank Unit
// Chooses one of the eight registers from the four addressing modes and
// drives it onto AEXT, and onto the internal bus or the data bus when read
// Also flags the AR writes to the address register as war
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mbu_read_select #(
   parameter logic [7:0] MBR_IO_BASE = 8'h08
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  mbu_pkg::mbu_raddr_e     raddr,
   input  mbu_pkg::mbu_waddr_e     waddr,
   input  logic [2:0]              ir,
   input  logic                    ir_idx,
   input  mbu_pkg::io_cycle_t      io,
   input  logic                    enabled,
   input  logic                    fpram_rom,
   input  logic [mbu_pkg::NUM_BANKS-1:0][mbu_pkg::BANK_DEPTH-1:0][mbu_pkg::MBU_REG_W-1:0] bank_q,
   output logic [7:0]              aext,
   output logic [7:0]              ibus_out,
   output logic                    ibus_oe,
   output logic [7:0]              db_out,
   output logic                    db_oe,
   output logic                    war
);

   import mbu_pkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // Decoding
   ////////////////////////////////////////////////////////////////////////////

   // Control unit reads MBP plus flags
   logic rmbp;

   // IN from one of the MBR ports
   logic io_rd;

   // Registered copy of the auto-index request
   logic idx_q;

   // Register address for the read, split into bank and entry
   logic [MBU_AW-1:0]         rd_addr;
   logic [MBU_AW-BANK_AW-1:0] rd_bank;
   logic [BANK_AW-1:0]        rd_entry;

   // Register chosen by the read address
   logic [MBU_REG_W-1:0] rd_data;

   assign rmbp = (raddr == RADDR_READ_MBP);

   // The four AR-write codes share the upper three waddr bits
   assign war = waddr inside {WADDR_WRITE_AR_MBP, WADDR_WRITE_AR_MBD,
                              WADDR_WRITE_AR_MBS, WADDR_WRITE_AR_IDX};

   // Same window match as the write side, qualified by the read strobe
   assign io_rd = io.sysdev && (io.ab[7:3] == MBR_IO_BASE[7:3]) && io.rd;

   // The control unit raises ir_idx one cycle ahead of the AR write that
   // wants IR to pick the bank register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idx_q <= 1'b0;
      end else begin
         idx_q <= ir_idx;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read addressing
   ////////////////////////////////////////////////////////////////////////////

   // Priority follows the old mux chain
   // Reading MBP wins, then the AR index modes, then the I/O address
   // AR codes 00 to 10 index through MB0 to MB2 directly
   // Code 11 indexes through MB3 unless auto-index is armed, in which case
   // the low three IR bits name the register
   // With nothing else going on the I/O address bus steers the read, so
   // AEXT follows whatever sits on ab[2:0]
   always_comb begin
      if (rmbp) begin
         rd_addr = '0;
      end else if (war) begin
         if (waddr[1:0] == 2'b11 && idx_q) begin
            rd_addr = ir;
         end else begin
            rd_addr = {1'b0, waddr[1:0]};
         end
      end else begin
         rd_addr = io.ab[MBU_AW-1:0];
      end
   end

   assign rd_bank  = rd_addr[MBU_AW-1:BANK_AW];
   assign rd_entry = rd_addr[BANK_AW-1:0];

   assign rd_data = bank_q[rd_bank][rd_entry];

   ////////////////////////////////////////////////////////////////////////////
   // Output buses
   ////////////////////////////////////////////////////////////////////////////

   // While disabled AEXT carries the power-on default
   // Bit 7 comes from the RAM/ROM switch so the processor starts in the
   // memory the front panel asks for
   always_comb begin
      if (enabled) begin
         aext = rd_data;
      end else begin
         aext = {fpram_rom, 7'b0};
      end
   end

   // Internal bus driver, used by the read-MBP microcode step
   assign ibus_out = aext;
   assign ibus_oe  = rmbp;

   // Data bus driver, used by IN from an MBR port
   assign db_out = aext;
   assign db_oe  = io_rd;

endmodule

`default_nettype wire

// ==== source/mbu.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory Bank Unit top level
// Eight 8-bit bank registers that extend the processor address on AEXT
// Written by the control unit and by OUT cycles, read four ways
// Set MBR_IO_BASE to place the registers in I/O space
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mbu #(
   parameter logic [7:0] MBR_IO_BASE = 8'h08
) (
   input  logic                    clk,
   input  logic                    rst_n,

   // Control unit side
   input  mbu_pkg::mbu_raddr_e     raddr,
   input  mbu_pkg::mbu_waddr_e     waddr,
   input  logic [2:0]              ir,
   input  logic                    ir_idx,

   // Processor I/O cycle and internal bus
   input  mbu_pkg::io_cycle_t      io,
   input  logic [7:0]              ibus_in,

   // RAM/ROM switch from the front panel
   input  logic                    fpram_rom,

   // Address extension and bus drivers
   output logic [7:0]              aext,
   output logic [7:0]              ibus_out,
   output logic                    ibus_oe,
   output logic [7:0]              db_out,
   output logic                    db_oe,

   // Tells the address register that an AR write is under way
   output logic                    war
);

   import mbu_pkg::*;

   // Shared write request, one enable bit per bank
   mbu_wr_t wr_req;

   // MBU online, set by the first OUT to the MBR window
   logic enabled;

   // Contents of every bank, tapped by the read side
   logic [NUM_BANKS-1:0][BANK_DEPTH-1:0][MBU_REG_W-1:0] bank_q;

   ////////////////////////////////////////////////////////////////////////////
   // Write decoder
   ////////////////////////////////////////////////////////////////////////////

   mbu_write_decode #(
      .MBR_IO_BASE (MBR_IO_BASE)
   ) write_decode_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .io      (io),
      .waddr   (waddr),
      .ibus_in (ibus_in),
      .wr_req  (wr_req),
      .enabled (enabled)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Register banks
   ////////////////////////////////////////////////////////////////////////////

   // Bank 0 holds MB0 to MB3, bank 1 holds MB4 to MB7
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      mbu_bank bank_inst (
         .clk    (clk),
         .rst_n  (rst_n),
         .wr_req (wr_req),
         .we     (wr_req.bank_we[i]),
         .q      (bank_q[i])
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read selector
   ////////////////////////////////////////////////////////////////////////////

   mbu_read_select #(
      .MBR_IO_BASE (MBR_IO_BASE)
   ) read_select_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .raddr     (raddr),
      .waddr     (waddr),
      .ir        (ir),
      .ir_idx    (ir_idx),
      .io        (io),
      .enabled   (enabled),
      .fpram_rom (fpram_rom),
      .bank_q    (bank_q),
      .aext      (aext),
      .ibus_out  (ibus_out),
      .ibus_oe   (ibus_oe),
      .db_out    (db_out),
      .db_oe     (db_oe),
      .war       (war)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_mbu.sv ====
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the Memory Bank Unit
// Keeps its own model of the eight registers and of the enable state and
// checks AEXT, IBUS, DB and war against it after every bus operation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_mbu;

   import mbu_pkg::*;

   localparam logic [7:0] MBR_IO_BASE = 8'h08;
   localparam int SEED = 45501;
   localparam int RESET_CYCLES = 16;

   // The five tests take just under 90 cycles with one idle cycle between
   // bus operations, so the limit leaves plenty of room
   localparam int TEST_CYCLES = 100;
   localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + TEST_CYCLES);

   // Codes outside the MBU's set, so the unit sees nothing for it
   localparam mbu_raddr_e RADDR_IDLE = mbu_raddr_e'(5'b00000);
   localparam mbu_waddr_e WADDR_IDLE = mbu_waddr_e'(5'b00000);
   localparam io_cycle_t  IO_IDLE = '0;

   logic       clk = 1'b0;
   logic       rst_n;
   mbu_raddr_e raddr;
   mbu_waddr_e waddr;
   logic [2:0] ir;
   logic       ir_idx;
   io_cycle_t  io;
   logic [7:0] ibus_in;
   logic       fpram_rom;
   logic [7:0] aext;
   logic [7:0] ibus_out;
   logic       ibus_oe;
   logic [7:0] db_out;
   logic       db_oe;
   logic       war;

   // Reference model of the register file and the enable flop
   logic [7:0] regs_m [8];
   logic       enabled_m;

   int errors = 0;
   int checks = 0;
   int cycle_count = 0;

   always #5 clk = ~clk;

   mbu #(
      .MBR_IO_BASE (MBR_IO_BASE)
   ) mbu_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .raddr     (raddr),
      .waddr     (waddr),
      .ir        (ir),
      .ir_idx    (ir_idx),
      .io        (io),
      .ibus_in   (ibus_in),
      .fpram_rom (fpram_rom),
      .aext      (aext),
      .ibus_out  (ibus_out),
      .ibus_oe   (ibus_oe),
      .db_out    (db_out),
      .db_oe     (db_oe),
      .war       (war)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Model and check helpers
   ////////////////////////////////////////////////////////////////////////////

   // The MBR window is eight ports aligned on the base address
   function automatic logic in_window(input logic [7:0] addr);
      return addr[7:3] == MBR_IO_BASE[7:3];
   endfunction

   // AEXT shows the addressed register once enabled, else the panel default
   function automatic logic [7:0] expected_aext(input logic [2:0] a);
      if (enabled_m) begin
         return regs_m[a];
      end
      return {fpram_rom, 7'b0};
   endfunction

   task automatic check_value(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp) else begin
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (errors == errs_before) begin
         $display("test %-24s ok", name);
      end else begin
         $display("test %-24s %0d errors", name, errors - errs_before);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus operations
   ////////////////////////////////////////////////////////////////////////////

   // OUT cycle that the MBU takes only when selected and inside the window
   task automatic io_write(input logic [7:0] addr, input logic sel,
                           input logic [7:0] data);
      @(posedge clk);
      io <= '{ab: addr, sysdev: sel, rd: 1'b0, wr: 1'b1};
      ibus_in <= data;
      @(posedge clk);
      io <= IO_IDLE;
      if (sel && in_window(addr)) begin
         regs_m[addr[2:0]] = data;
         enabled_m = 1'b1;
      end
   endtask

   // IN cycle where DB is driven only for a selected port in the window
   task automatic io_read(input logic [7:0] addr, input logic sel);
      @(posedge clk);
      io <= '{ab: addr, sysdev: sel, rd: 1'b1, wr: 1'b0};
      @(negedge clk);
      check_flag("db_oe", db_oe, sel && in_window(addr));
      check_value("db_out", db_out, expected_aext(addr[2:0]));
      @(posedge clk);
      io <= IO_IDLE;
   endtask

   // Control unit write of MBP with or without flags
   task automatic cu_write_mbp(input mbu_waddr_e code, input logic [7:0] data);
      @(posedge clk);
      waddr <= code;
      ibus_in <= data;
      @(posedge clk);
      waddr <= WADDR_IDLE;
      regs_m[0] = data;
   endtask

   // Control unit read of MBP onto the internal bus
   // The address bus points at MB3 meanwhile, and the read must still see MB0
   task automatic cu_read_mbp();
      @(posedge clk);
      raddr <= RADDR_READ_MBP;
      io <= '{ab: MBR_IO_BASE + 8'd3, sysdev: 1'b0, rd: 1'b0, wr: 1'b0};
      @(negedge clk);
      check_flag("ibus_oe", ibus_oe, 1'b1);
      check_value("ibus_out", ibus_out, expected_aext(3'd0));
      @(posedge clk);
      raddr <= RADDR_IDLE;
      io <= IO_IDLE;
   endtask

   // With no strobes the address bus low bits steer AEXT
   task automatic check_aext_at(input logic [7:0] addr);
      @(posedge clk);
      io <= '{ab: addr, sysdev: 1'b0, rd: 1'b0, wr: 1'b0};
      @(negedge clk);
      check_value("aext", aext, expected_aext(addr[2:0]));
      check_flag("ibus_oe", ibus_oe, 1'b0);
      check_flag("db_oe", db_oe, 1'b0);
   endtask

   // AR write code with ir_idx armed or not on the cycle before
   // The caller names the register that the code must select
   task automatic ar_select(input mbu_waddr_e code, input logic [2:0] ir_val,
                            input logic arm, input logic [2:0] exp_reg);
      @(posedge clk);
      ir_idx <= arm;
      @(posedge clk);
      ir_idx <= 1'b0;
      waddr <= code;
      ir <= ir_val;
      @(negedge clk);
      check_flag("war", war, 1'b1);
      check_value("aext", aext, expected_aext(exp_reg));
      @(posedge clk);
      waddr <= WADDR_IDLE;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_reset_default();
      int errs_before;
      errs_before = errors;
      @(posedge clk);
      fpram_rom <= 1'b0;
      check_aext_at(MBR_IO_BASE);
      @(posedge clk);
      fpram_rom <= 1'b1;
      check_aext_at(MBR_IO_BASE);
      // A write from the control unit alone keeps the default on AEXT
      cu_write_mbp(WADDR_WRITE_MBP, 8'h3c);
      check_aext_at(MBR_IO_BASE);
      io_write(MBR_IO_BASE + 8'd5, 1'b1, 8'ha5);
      check_aext_at(MBR_IO_BASE + 8'd5);
      check_aext_at(MBR_IO_BASE);
      report_test("reset_default", errs_before);
   endtask

   task automatic test_io_access();
      int errs_before;
      logic [7:0] rnd;
      errs_before = errors;
      // Low bits carry the index so every register holds a distinct value
      for (int i = 0; i < 8; i++) begin
         rnd = 8'($urandom());
         io_write(8'(MBR_IO_BASE + i), 1'b1, {rnd[7:3], 3'(i)});
      end
      for (int i = 0; i < 8; i++) begin
         io_read(8'(MBR_IO_BASE + i), 1'b1);
      end
      // Not selected, then outside the window
      io_write(MBR_IO_BASE + 8'd2, 1'b0, 8'hee);
      io_write(8'h12, 1'b1, 8'hdd);
      io_read(MBR_IO_BASE + 8'd2, 1'b1);
      io_read(MBR_IO_BASE + 8'd2, 1'b0);
      io_read(8'h12, 1'b1);
      report_test("io_access", errs_before);
   endtask

   task automatic test_cu_mbp();
      int errs_before;
      errs_before = errors;
      cu_write_mbp(WADDR_WRITE_MBP, 8'(($urandom() & 32'hf0) | 32'h01));
      cu_read_mbp();
      cu_write_mbp(WADDR_WRITE_MBP_FLAGS, 8'(($urandom() & 32'hf0) | 32'h02));
      cu_read_mbp();
      io_read(MBR_IO_BASE, 1'b1);
      report_test("cu_mbp", errs_before);
   endtask

   task automatic test_ar_index();
      int errs_before;
      errs_before = errors;
      ar_select(WADDR_WRITE_AR_MBP, 3'd6, 1'b0, 3'd0);
      ar_select(WADDR_WRITE_AR_MBD, 3'd6, 1'b0, 3'd1);
      ar_select(WADDR_WRITE_AR_MBS, 3'd6, 1'b1, 3'd2);
      ar_select(WADDR_WRITE_AR_IDX, 3'd6, 1'b0, 3'd3);
      // Auto-index lets IR name any register, in either bank
      ar_select(WADDR_WRITE_AR_IDX, 3'd5, 1'b1, 3'd5);
      ar_select(WADDR_WRITE_AR_IDX, 3'd2, 1'b1, 3'd2);
      @(negedge clk);
      check_flag("war", war, 1'b0);
      report_test("ar_index", errs_before);
   endtask

   task automatic test_write_clash();
      int errs_before;
      errs_before = errors;
      @(posedge clk);
      waddr <= WADDR_WRITE_MBP;
      io <= '{ab: MBR_IO_BASE + 8'd6, sysdev: 1'b1, rd: 1'b0, wr: 1'b1};
      ibus_in <= ~regs_m[0];
      @(posedge clk);
      waddr <= WADDR_IDLE;
      io <= IO_IDLE;
      regs_m[6] = ~regs_m[0];
      io_read(MBR_IO_BASE, 1'b1);
      io_read(MBR_IO_BASE + 8'd6, 1'b1);
      report_test("write_clash", errs_before);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Run control
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      void'($urandom(SEED));
      foreach (regs_m[i]) begin
         regs_m[i] = 8'h00;
      end
      enabled_m = 1'b0;
      rst_n <= 1'b0;
      raddr <= RADDR_IDLE;
      waddr <= WADDR_IDLE;
      ir <= 3'd0;
      ir_idx <= 1'b0;
      io <= IO_IDLE;
      ibus_in <= 8'h00;
      fpram_rom <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      test_reset_default();
      test_io_access();
      test_cu_mbp();
      test_ar_index();
      test_write_clash();
      $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/mbu_pkg.sv
source/mbu_write_decode.sv
source/mbu_bank.sv
source/mbu_read_select.sv
source/mbu.sv
testbench/tb_mbu.sv

// ==== Makefile ====
# Verilator build and run for the MBU testbench

VERILATOR ?= verilator
TOP       ?= tb_mbu
FLAGS     ?= -j 0
OBJ_DIR   ?= obj_dir

SOURCES := $(filter %.sv %.v,$(shell cat verilog.f))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) verilog.f
	$(VERILATOR) --binary --timing --assert $(FLAGS) \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -f verilog.f

# Fails unless the testbench prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
